// File: src.f
+incdir+tb
src/spi_bridge_pkg.sv
src/apb_spi_regs.sv
src/spi_shift_engine.sv
src/spi_slave_fanout.sv
src/spi_bridge_top.sv
tb/spi_bridge_tb.sv

// File: src/apb_spi_regs.sv
// apb3 slave on clk_fpga; txdata writes stall while busy, everything else is zero-wait
`timescale 1ns/1ps

module apb_spi_regs (
   input  logic                                clk_fpga,
   input  logic                                arst_n,
   // apb3
   input  logic [spi_bridge_pkg::paddr_w-1:0]  paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic                                pready,
   // engine side
   output spi_bridge_pkg::spi_cmd_t            cmd,
   input  spi_bridge_pkg::spi_rsp_t            rsp,
   output logic                                irq
);
   import spi_bridge_pkg::*;

   spi_ctrl_t   ctrl_q;
   spi_word_u   wword;       // incoming write word, two views
   logic [31:0] txd_q;
   logic [31:0] rxd_q;       // last received word
   logic        start_q;
   logic        irq_q;       // sticky until status read
   logic        wr_acc;
   logic        rd_acc;
   logic        stall;

   ////////////////////////////////////////////////////////////////////////////
   // access decode

   assign wword.data = pwdata;
   assign wr_acc     = psel & penable & pwrite;
   assign rd_acc     = psel & penable & ~pwrite;

   // start_q counts as busy, engine sees it one cycle late
   assign stall  = wr_acc & (paddr == reg_txdata) & (rsp.busy | start_q);
   assign pready = ~stall;

   ////////////////////////////////////////////////////////////////////////////
   // registers

   always_ff @(posedge clk_fpga or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_q  <= '0;
         txd_q   <= '0;
         rxd_q   <= '0;
         start_q <= 1'b0;
         irq_q   <= 1'b0;
      end else begin
         start_q <= 1'b0;                          // single-cycle pulse
         if (wr_acc && pready) begin
            case (paddr)
               reg_ctrl: begin
                  ctrl_q        <= '0;             // reserved bits read back zero
                  ctrl_q.slave  <= wword.ctrl.slave;
                  ctrl_q.len_m1 <= wword.ctrl.len_m1;
                  ctrl_q.irq_en <= wword.ctrl.irq_en;
               end
               reg_txdata: begin
                  txd_q   <= wword.data;
                  start_q <= 1'b1;                 // launch on next clock
               end
               default: ;                          // rxdata, status read only
            endcase
         end
         if (rsp.done) rxd_q <= rsp.rdata;          // latch reply
         // set beats clear when both land together
         if (rsp.done && ctrl_q.irq_en) begin
            irq_q <= 1'b1;
         end else if (rd_acc && (paddr == reg_status)) begin
            irq_q <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read mux, no wait states

   always_comb begin
      case (paddr)
         reg_ctrl:   prdata = ctrl_q;
         reg_txdata: prdata = txd_q;
         reg_rxdata: prdata = rxd_q;
         reg_status: prdata = {30'd0, irq_q, rsp.busy};  // bit1 irq, bit0 busy
         default:    prdata = 32'd0;
      endcase
   end

   // command to the engine, ctrl fields sampled by the engine at start
   assign cmd.start = start_q;
   assign cmd.slave = ctrl_q.slave;
   assign cmd.len   = ctrl_q.len_m1;
   assign cmd.data  = txd_q;

   assign irq = irq_q;

endmodule

// File: src/spi_bridge_pkg.sv
// shared map and types of the spi bridge; four slaves and a 2-cycle sclk half period are fixed here
package spi_bridge_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes and constants
   localparam int num_slaves = 4;
   localparam int sel_w      = $clog2(num_slaves);  // select index width
   localparam int sclk_div   = 2;                   // clk_fpga cycles per sclk half period
   localparam int sclk_cnt_w = (sclk_div > 1) ? $clog2(sclk_div) : 1;
   localparam int paddr_w    = 4;                   // enough for four word registers

   // slave select indices, board order
   localparam logic [sel_w-1:0] slv_db_tx = 2'd0;
   localparam logic [sel_w-1:0] slv_db_rx = 2'd1;
   localparam logic [sel_w-1:0] slv_codec = 2'd2;
   localparam logic [sel_w-1:0] slv_cgen  = 2'd3;   // also reachable over the aux path

   // register offsets
   localparam logic [paddr_w-1:0] reg_ctrl   = 4'h0;
   localparam logic [paddr_w-1:0] reg_txdata = 4'h4;  // write launches a transfer
   localparam logic [paddr_w-1:0] reg_rxdata = 4'h8;
   localparam logic [paddr_w-1:0] reg_status = 4'hC;  // read clears irq

   ////////////////////////////////////////////////////////////////////////////
   // control word, slave index in the low bits
   typedef struct packed {
      logic [23:0]      rsvd;
      logic             irq_en;
      logic [4:0]       len_m1;   // bit count minus one
      logic [sel_w-1:0] slave;
   } spi_ctrl_t;

   // one apb write word, seen as ctrl or raw shift data by address
   typedef union packed {
      spi_ctrl_t   ctrl;
      logic [31:0] data;
   } spi_word_u;

   typedef struct packed {
      logic             start;    // one-cycle pulse
      logic [sel_w-1:0] slave;
      logic [4:0]       len;      // bits minus one
      logic [31:0]      data;
   } spi_cmd_t;

   typedef struct packed {
      logic        busy;
      logic        done;          // one-cycle pulse, rdata valid
      logic [31:0] rdata;
   } spi_rsp_t;

   typedef struct packed {
      logic sclk;
      logic mosi;
      logic act;                  // a slave is selected
   } spi_lines_t;

endpackage

// File: src/spi_bridge_top.sv
// top of the apb to spi bridge; pclk is clk_fpga, slave pins are indexed by select index
`timescale 1ns/1ps

module spi_bridge_top (
   input  logic                                  clk_fpga,
   input  logic                                  arst_n,
   // apb3 slave
   input  logic [spi_bridge_pkg::paddr_w-1:0]    paddr,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [31:0]                           pwdata,
   output logic [31:0]                           prdata,
   output logic                                  pready,
   // spi slaves
   output logic [spi_bridge_pkg::num_slaves-1:0] slv_sclk,
   output logic [spi_bridge_pkg::num_slaves-1:0] slv_sen_n,
   output logic [spi_bridge_pkg::num_slaves-1:0] slv_mosi,
   input  logic [spi_bridge_pkg::num_slaves-1:0] slv_miso,
   // aux spi to cgen
   input  logic                                  aux_sclk,
   input  logic                                  aux_sen_n,
   input  logic                                  aux_mosi,
   output logic                                  aux_miso_irq
);
   import spi_bridge_pkg::*;

   spi_cmd_t         cmd;
   spi_rsp_t         rsp;
   spi_lines_t       lines;
   logic [sel_w-1:0] sel;
   logic             miso;       // merged return
   logic             irq;

   // register file, input side
   apb_spi_regs u_regs (
      .clk_fpga (clk_fpga), .arst_n (arst_n),
      .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
      .pwdata (pwdata), .prdata (prdata), .pready (pready),
      .cmd (cmd), .rsp (rsp), .irq (irq)
   );

   spi_shift_engine u_engine (
      .clk_fpga (clk_fpga), .arst_n (arst_n),
      .cmd (cmd), .rsp (rsp), .lines (lines), .sel (sel), .miso (miso)
   );

   // pin side
   spi_slave_fanout u_fanout (
      .lines (lines), .sel (sel),
      .aux_sclk (aux_sclk), .aux_sen_n (aux_sen_n), .aux_mosi (aux_mosi), .irq (irq),
      .slv_sclk (slv_sclk), .slv_sen_n (slv_sen_n), .slv_mosi (slv_mosi),
      .slv_miso (slv_miso), .miso (miso), .aux_miso_irq (aux_miso_irq)
   );

endmodule

// File: src/spi_shift_engine.sv
// spi mode-0 master, msb first, 1 to 32 bits; slave and length are latched at start
`timescale 1ns/1ps

module spi_shift_engine (
   input  logic                             clk_fpga,
   input  logic                             arst_n,
   input  spi_bridge_pkg::spi_cmd_t         cmd,
   output spi_bridge_pkg::spi_rsp_t         rsp,
   output spi_bridge_pkg::spi_lines_t       lines,
   output logic [spi_bridge_pkg::sel_w-1:0] sel,
   input  logic                             miso
);
   import spi_bridge_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_shift,
      st_finish
   } state_t;

   state_t                state;
   logic [sclk_cnt_w-1:0] hcnt;     // half-period counter
   logic [4:0]            bcnt;     // bits left minus one
   logic [31:0]           sreg;     // tx shifter, active bit at msb
   logic [31:0]           rx_q;     // rx shifter, fills from lsb
   logic [sel_w-1:0]      sel_q;
   logic                  sclk_q;
   logic                  act_q;
   logic                  done_q;

   ////////////////////////////////////////////////////////////////////////////
   // fsm and shifters

   always_ff @(posedge clk_fpga or negedge arst_n) begin
      if (!arst_n) begin
         state  <= st_idle;
         hcnt   <= '0;
         bcnt   <= '0;
         sreg   <= '0;
         rx_q   <= '0;
         sel_q  <= '0;
         sclk_q <= 1'b0;
         act_q  <= 1'b0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state)
            st_idle: begin
               if (cmd.start) begin
                  state <= st_shift;
                  act_q <= 1'b1;                   // sen_n drops next cycle
                  sel_q <= cmd.slave;
                  bcnt  <= cmd.len;
                  hcnt  <= '0;
                  // left-justify so the first bit sits on mosi already
                  sreg  <= cmd.data << (5'd31 - cmd.len);
                  rx_q  <= '0;
               end
            end
            st_shift: begin
               if (hcnt == sclk_cnt_w'(sclk_div - 1)) begin
                  hcnt   <= '0;
                  sclk_q <= ~sclk_q;
                  if (!sclk_q) begin
                     rx_q <= {rx_q[30:0], miso};   // rising edge, sample
                  end else if (bcnt == 5'd0) begin
                     state <= st_finish;           // last falling edge
                  end else begin
                     bcnt <= bcnt - 5'd1;
                     sreg <= {sreg[30:0], 1'b0};   // falling edge, next bit out
                  end
               end else begin
                  hcnt <= hcnt + 1'b1;
               end
            end
            st_finish: begin
               act_q  <= 1'b0;                     // deselect
               done_q <= 1'b1;
               sreg   <= '0;                       // park mosi low
               state  <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // done shows up together with busy falling
   assign rsp.busy  = (state != st_idle);
   assign rsp.done  = done_q;
   assign rsp.rdata = rx_q;                        // right-aligned by construction

   assign lines.sclk = sclk_q;
   assign lines.mosi = sreg[31];
   assign lines.act  = act_q;
   assign sel        = sel_q;

endmodule

// File: src/spi_slave_fanout.sv
// purely combinational; an active aux select overrides the engine on the cgen pins
`timescale 1ns/1ps

module spi_slave_fanout (
   input  spi_bridge_pkg::spi_lines_t            lines,
   input  logic [spi_bridge_pkg::sel_w-1:0]      sel,
   // aux path for the clock generator
   input  logic                                  aux_sclk,
   input  logic                                  aux_sen_n,
   input  logic                                  aux_mosi,
   input  logic                                  irq,
   // slave pins
   output logic [spi_bridge_pkg::num_slaves-1:0] slv_sclk,
   output logic [spi_bridge_pkg::num_slaves-1:0] slv_sen_n,
   output logic [spi_bridge_pkg::num_slaves-1:0] slv_mosi,
   input  logic [spi_bridge_pkg::num_slaves-1:0] slv_miso,
   output logic                                  miso,
   output logic                                  aux_miso_irq
);
   import spi_bridge_pkg::*;

   logic [num_slaves-1:0] eng_sen_n;   // engine selects, before aux override

   ////////////////////////////////////////////////////////////////////////////
   // select decode and gating

   always_comb begin
      for (int i = 0; i < num_slaves; i++) begin
         eng_sen_n[i] = ~(lines.act & (sel == sel_w'(i)));
         slv_sen_n[i] = eng_sen_n[i];
         slv_sclk[i]  = lines.sclk & ~eng_sen_n[i];  // idle slaves see no edges
         slv_mosi[i]  = lines.mosi & ~eng_sen_n[i];
      end
      // host drives cgen directly while aux select is low
      if (!aux_sen_n) begin
         slv_sclk[slv_cgen]  = aux_sclk;
         slv_sen_n[slv_cgen] = aux_sen_n;
         slv_mosi[slv_cgen]  = aux_mosi;
      end
   end

   // unselected slaves are masked off, so their miso is don't-care
   assign miso = |(slv_miso & ~eng_sen_n);

   // return pin doubles as interrupt when aux is idle
   assign aux_miso_irq = aux_sen_n ? irq : slv_miso[slv_cgen];

endmodule

// File: tb/spi_bridge_tb_tasks.svh
// included inside spi_bridge_tb; apb accesses start after a clock edge and leave the bus idle
`ifndef SPI_BRIDGE_TB_TASKS_SVH
`define SPI_BRIDGE_TB_TASKS_SVH

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
   if (actual !== expected) begin
      $display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
   end
endtask

// ctrl word with slave in [1:0], length minus one in [6:2] and irq enable in [7]
function automatic logic [31:0] ctrl_word(input int slave, input int len, input logic irq_en);
   return {24'd0, irq_en, 5'(len - 1), 2'(slave)};
endfunction

function automatic logic [31:0] low_mask(input int len);
   return (len >= 32) ? 32'hffff_ffff : ((32'd1 << len) - 32'd1);
endfunction

task automatic write_reg(input logic [paddr_w-1:0] addr, input logic [31:0] data,
                         output int waits);
   waits = 0;
   @(posedge clk_fpga);
   #2;
   paddr   = addr;                     // setup phase
   pwdata  = data;
   pwrite  = 1'b1;
   psel    = 1'b1;
   penable = 1'b0;
   @(posedge clk_fpga);
   #2;
   penable = 1'b1;
   @(negedge clk_fpga);                // pready settled mid-cycle
   while (!pready) begin
      waits++;
      @(negedge clk_fpga);
   end
   @(posedge clk_fpga);                // access completes here
   #2;
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic read_reg(input logic [paddr_w-1:0] addr, output logic [31:0] data);
   @(posedge clk_fpga);
   #2;
   paddr   = addr;
   pwrite  = 1'b0;
   psel    = 1'b1;
   penable = 1'b0;
   @(posedge clk_fpga);
   #2;
   penable = 1'b1;
   @(negedge clk_fpga);
   check("pready on read", 1, pready);   // reads never wait
   data = prdata;
   @(posedge clk_fpga);
   #2;
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic wait_idle();
   logic [31:0] st;
   st = 32'h1;
   while (st[0]) read_reg(reg_status, st);   // bit0 busy
endtask

task automatic clear_models();
   for (int i = 0; i < num_slaves; i++) begin
      rcvd[i]   = '0;
      nbits[i]  = 0;
      nedges[i] = 0;
   end
   seen_sel = '0;
endtask

// only the chosen slave may see a select and sclk edges
task automatic check_selects(input int slave, input int len);
   for (int i = 0; i < num_slaves; i++) begin
      check($sformatf("slv_sclk[%0d] edges", i), (i == slave) ? len : 0, nedges[i]);
      check($sformatf("slv_sen_n[%0d] went low", i), i == slave, seen_sel[i]);
   end
   check("slv_sen_n after transfer", 4'hf, slv_sen_n);
endtask

task automatic run_transfer(input int slave, input int len, input logic [31:0] word,
                            input logic [31:0] reply);
   int          waits;
   logic [31:0] rdata;
   write_reg(reg_ctrl, ctrl_word(slave, len, 1'b0), waits);
   clear_models();
   shout[slave] = reply << (32 - len);   // reply bits go out first
   write_reg(reg_txdata, word, waits);
   check("txdata wait states while idle", 0, waits);
   wait_idle();
   check_selects(slave, len);
   check($sformatf("slave %0d mosi word", slave), word & low_mask(len), rcvd[slave]);
   read_reg(reg_rxdata, rdata);
   check("rxdata", reply & low_mask(len), rdata);
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests

task automatic check_reset_state();
   logic [31:0] rdata;
   check("slv_sen_n", 4'hf, slv_sen_n);
   check("slv_sclk", 0, slv_sclk);
   check("slv_mosi", 0, slv_mosi);
   check("aux_miso_irq", 0, aux_miso_irq);
   for (int a = 0; a < 4; a++) begin
      read_reg(paddr_w'(4 * a), rdata);   // ctrl, txdata, rxdata, status
      check($sformatf("register 0x%0h after reset", 4 * a), 0, rdata);
   end
endtask

task automatic random_transfers();
   int len;
   for (int s = 0; s < num_slaves; s++) begin
      for (int k = 0; k < 3; k++) begin
         len = $urandom_range(32, 1);
         run_transfer(s, len, $urandom, $urandom);
      end
   end
   run_transfer(slv_codec, 32, 32'h8000_0001, 32'hffff_0000);   // full width
   run_transfer(slv_db_tx, 1, 32'h1, 32'h1);                   // single bit
endtask

task automatic back_to_back_write();
   int          waits;
   logic [31:0] rdata;
   write_reg(reg_ctrl, ctrl_word(slv_db_rx, 12, 1'b0), waits);
   clear_models();
   shout[slv_db_rx] = {12'h5a3, 12'hc3e, 8'h00};   // two replies back to back
   write_reg(reg_txdata, 32'h0000_0abc, waits);
   write_reg(reg_ctrl, ctrl_word(slv_db_rx, 12, 1'b0), waits);   // same setup mid-transfer
   check("ctrl write wait states while busy", 0, waits);
   write_reg(reg_txdata, 32'h0000_0123, waits);   // lands while busy
   check("second txdata stalled", 1, waits > 0);
   check("bits done at second write", 12, nbits[slv_db_rx]);
   wait_idle();
   check("mosi of both transfers", 32'h00ab_c123, rcvd[slv_db_rx]);
   check("slv_sclk edges of both", 24, nedges[slv_db_rx]);
   read_reg(reg_rxdata, rdata);
   check("rxdata of second transfer", 32'h0000_0c3e, rdata);
endtask

task automatic interrupt_flag();
   int          waits;
   logic [31:0] rdata;
   write_reg(reg_ctrl, ctrl_word(slv_cgen, 8, 1'b1), waits);
   clear_models();
   shout[slv_cgen] = 32'h9600_0000;
   write_reg(reg_txdata, 32'h0000_0042, waits);
   check("aux_miso_irq during transfer", 0, aux_miso_irq);
   while (!aux_miso_irq) @(negedge clk_fpga);
   check("bits before irq", 8, nbits[slv_cgen]);
   read_reg(reg_status, rdata);
   check("status with irq", 32'h2, rdata);
   @(negedge clk_fpga);
   check("aux_miso_irq after status read", 0, aux_miso_irq);
   read_reg(reg_rxdata, rdata);
   check("rxdata", 32'h0000_0096, rdata);
   // enable clear, pin watched with no status read in between
   write_reg(reg_ctrl, ctrl_word(slv_cgen, 8, 1'b0), waits);
   clear_models();
   shout[slv_cgen] = 32'h3c00_0000;
   write_reg(reg_txdata, 32'h0000_005a, waits);
   while (!seen_sel[slv_cgen]) @(negedge clk_fpga);
   while (!slv_sen_n[slv_cgen]) @(negedge clk_fpga);   // transfer over
   repeat (4) begin
      @(negedge clk_fpga);
      check("aux_miso_irq with enable clear", 0, aux_miso_irq);
   end
   read_reg(reg_status, rdata);
   check("status with enable clear", 32'h0, rdata);
   check("mosi with enable clear", 32'h0000_005a, rcvd[slv_cgen]);
   read_reg(reg_rxdata, rdata);
   check("rxdata with enable clear", 32'h0000_003c, rdata);
endtask

task automatic aux_bypass();
   for (int k = 0; k < 4; k++) begin
      @(posedge clk_fpga);
      #2;
      aux_sen_n = 1'b0;
      aux_sclk  = k[0];
      aux_mosi  = k[1];
      @(negedge clk_fpga);
      shout[slv_cgen][31] = k[0] ^ k[1];   // cgen reply bit
      #1;
      check("slv_sen_n under aux", 4'b0111, slv_sen_n);
      check("slv_sclk[cgen]", k[0], slv_sclk[slv_cgen]);
      check("slv_mosi[cgen]", k[1], slv_mosi[slv_cgen]);
      check("aux_miso_irq as cgen miso", k[0] ^ k[1], aux_miso_irq);
   end
   @(posedge clk_fpga);
   #2;
   aux_sen_n = 1'b1;
   aux_sclk  = 1'b0;
   aux_mosi  = 1'b0;
   @(negedge clk_fpga);
   check("slv_sen_n after aux release", 4'hf, slv_sen_n);
endtask

`endif

// File: tb/spi_bridge_tb.sv
// slave models are mode 0 and hold one 32-bit reply each; run stops at 4000 clk_fpga cycles
`timescale 1ns/1ps

module spi_bridge_tb;
   import spi_bridge_pkg::*;

   localparam int max_cycles = 4000;   // about 4x the summed transfer time

   logic                  clk_fpga;
   logic                  arst_n;
   logic [paddr_w-1:0]    paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [31:0]           pwdata;
   logic [31:0]           prdata;
   logic                  pready;
   logic [num_slaves-1:0] slv_sclk;
   logic [num_slaves-1:0] slv_sen_n;
   logic [num_slaves-1:0] slv_mosi;
   wire  [num_slaves-1:0] slv_miso;
   logic                  aux_sclk;
   logic                  aux_sen_n;
   logic                  aux_mosi;
   logic                  aux_miso_irq;
   int                    cycles;

   // slave model state
   logic [31:0]           shout  [num_slaves];   // reply shifter with msb on miso
   logic [31:0]           rcvd   [num_slaves];   // mosi bits with the newest at lsb
   int                    nbits  [num_slaves];
   int                    nedges [num_slaves];   // every sclk rise whether selected or not
   logic [num_slaves-1:0] seen_sel;
   logic [num_slaves-1:0] noise;                 // miso of idle slaves

   spi_bridge_top uut (
      .clk_fpga (clk_fpga), .arst_n (arst_n),
      .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
      .pwdata (pwdata), .prdata (prdata), .pready (pready),
      .slv_sclk (slv_sclk), .slv_sen_n (slv_sen_n), .slv_mosi (slv_mosi),
      .slv_miso (slv_miso),
      .aux_sclk (aux_sclk), .aux_sen_n (aux_sen_n), .aux_mosi (aux_mosi),
      .aux_miso_irq (aux_miso_irq)
   );

   `include "spi_bridge_tb_tasks.svh"

   ////////////////////////////////////////////////////////////////////////////
   // clock, watchdog, slave models

   always #20 clk_fpga = ~clk_fpga;   // 40 ns period

   always @(posedge clk_fpga) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
         $display("Finished with errors");
         $fatal(1, "watchdog expired");
      end
   end

   always @(posedge clk_fpga) #2 noise = 4'($urandom);

   for (genvar g = 0; g < num_slaves; g++) begin : g_model
      assign slv_miso[g] = slv_sen_n[g] ? noise[g] : shout[g][31];
      always @(negedge slv_sen_n[g]) seen_sel[g] = 1'b1;
      always @(posedge slv_sclk[g]) begin
         nedges[g] = nedges[g] + 1;
         if (!slv_sen_n[g]) begin
            rcvd[g]  = {rcvd[g][30:0], slv_mosi[g]};   // mode 0 samples on the rise
            nbits[g] = nbits[g] + 1;
         end
      end
      always @(negedge slv_sclk[g]) begin
         if (!slv_sen_n[g]) shout[g] = {shout[g][30:0], 1'b0};  // next reply bit
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // test sequence

   initial begin
      void'($urandom(32'h54c0a057));
      clk_fpga  = 1'b0;
      arst_n    = 1'b0;
      paddr     = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = '0;
      aux_sclk  = 1'b0;
      aux_sen_n = 1'b1;   // aux idle so the pin shows irq
      aux_mosi  = 1'b0;
      noise     = '0;
      cycles    = 0;
      clear_models();
      for (int i = 0; i < num_slaves; i++) shout[i] = '0;
      repeat (3) @(posedge clk_fpga);
      #2 arst_n = 1'b1;
      check_reset_state();
      random_transfers();
      back_to_back_write();
      interrupt_flag();
      aux_bypass();
      $display("Finished with no errors");
      $finish;
   end

endmodule
